/* laser_particle_detect.f */
+incdir+verif
common/laser_data_pkg.sv
common/laser_ctrl_pkg.sv
common/ds_sample_if.sv
common/filter_result_if.sv
downsample/uniform_downsample.sv
particle_filter/particle_filter.sv
acc_flag/acc_flag_generate.sv
design/acc_event_stats.sv
design/laser_particle_detect.sv
verif/tb_laser_particle_detect.sv

/* Bender.yml */
package:
  name: laser_particle_detect

sources:
  - files:
      - common/laser_data_pkg.sv
      - common/laser_ctrl_pkg.sv
      - common/ds_sample_if.sv
      - common/filter_result_if.sv
      - downsample/uniform_downsample.sv
      - particle_filter/particle_filter.sv
      - acc_flag/acc_flag_generate.sv
      - design/acc_event_stats.sv
      - design/laser_particle_detect.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_laser_particle_detect.sv

/* verif/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// running totals for the closing line
int err_cnt = 0;
int chk_cnt = 0;

// kept sample payload
task automatic check_sample(input string test, input string what,
                            input laser_data_pkg::sample_t exp_v,
                            input laser_data_pkg::sample_t act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
        err_cnt++;
        $display("error %s %s: expected %h, actual %h", test, what, exp_v, act_v);
    end
endtask

// accumulated result bit
task automatic check_bit(input string test, input string what,
                         input logic exp_v, input logic act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
        err_cnt++;
        $display("error %s %s: expected %b, actual %b", test, what, exp_v, act_v);
    end
endtask

// widened sources, cache/curr/pre from msb down
task automatic check_src_vec(input string test, input string what,
                             input laser_ctrl_pkg::src_vec_t exp_v,
                             input laser_ctrl_pkg::src_vec_t act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
        err_cnt++;
        $display("error %s %s: expected %b, actual %b", test, what, exp_v, act_v);
    end
endtask

// per-track edge counters
task automatic check_count(input string test, input string what,
                           input laser_data_pkg::evt_cnt_t exp_v,
                           input laser_data_pkg::evt_cnt_t act_v);
    chk_cnt++;
    if (act_v !== exp_v) begin
        err_cnt++;
        $display("error %s %s: expected %0d, actual %0d", test, what, exp_v, act_v);
    end
endtask

`endif

/* verif/tb_laser_particle_detect.sv */
`timescale 1ns/100ps

module tb_laser_particle_detect;

    import laser_data_pkg::*;
    import laser_ctrl_pkg::*;

    `include "tb_checks.svh"

    // one track per row
    typedef struct {
        string   name;
        ratio_t  ratio;
        thre_t   curr_thre;
        thre_t   cache_thre;
        width_t  width;
        bypass_t bypass;
        logic    en;
        int      n_samples;
        // up to gap_max idle cycles before a valid sample
        int      gap_max;
    } test_row_t;

    localparam int N_ROWS = 8;

    logic     clk_i = 1'b0;
    logic     reset_i;
    ratio_t   ds_ratio_i;
    logic     ds_ratio_en_i;
    logic     laser_start_i;
    logic     laser_vld_i;
    sample_t  laser_data_i;
    logic     pre_track_result_i;
    thre_t    curr_thre_i;
    thre_t    cache_thre_i;
    width_t   detect_width_i;
    bypass_t  particle_acc_bypass_i;
    logic     acc_defect_en_i;
    logic     filter_acc_vld_o;
    sample_t  filter_acc_data_o;
    logic     filter_acc_result_o;
    logic     acc_pre_result_o;
    logic     acc_curr_result_o;
    logic     acc_cache_result_o;
    evt_cnt_t acc_result_cnt_o;
    evt_cnt_t pre_widen_cnt_o;
    evt_cnt_t curr_widen_cnt_o;
    evt_cnt_t cache_widen_cnt_o;

    test_row_t rows [N_ROWS];
    string     cur_name = "reset";
    integer    seed;
    int        cycle_cnt = 0;
    int        limit = 0;

    // expected output strobes in order
    sample_t  exp_data [$];
    src_vec_t exp_wid [$];
    logic     exp_acc [$];

    laser_particle_detect i_dut (.*);

    always #4 clk_i = ~clk_i;

    // uniform draw in 0 .. n-1
    function automatic int rand_below(input int n);
        int v;
        v = $random(seed);
        return (v & 32'h7fff_ffff) % n;
    endfunction

    // sample counts with a ratio above one end mid count
    task automatic load_table();
        rows[0] = '{"ratio_1",    16'd1, 16'h8000, 16'h1000, 16'd1, 3'b000, 1'b1, 40, 2};
        rows[1] = '{"ratio_3",    16'd3, 16'h8000, 16'h1000, 16'd1, 3'b000, 1'b1, 61, 1};
        rows[2] = '{"ratio_0",    16'd0, 16'h8000, 16'h1000, 16'd1, 3'b000, 1'b1, 40, 0};
        rows[3] = '{"hits_w1",    16'd1, 16'hc000, 16'h2000, 16'd1, 3'b000, 1'b1, 50, 1};
        rows[4] = '{"widen_w4",   16'd2, 16'he000, 16'h6000, 16'd4, 3'b000, 1'b1, 81, 2};
        rows[5] = '{"bypass_101", 16'd1, 16'hd000, 16'h4000, 16'd3, 3'b101, 1'b1, 50, 1};
        rows[6] = '{"bypass_111", 16'd1, 16'h8000, 16'h1000, 16'd2, 3'b111, 1'b1, 40, 1};
        rows[7] = '{"enable_low", 16'd1, 16'h8000, 16'h1000, 16'd2, 3'b000, 1'b0, 40, 3};
    endtask

    task automatic check_all_counts(input evt_cnt_t cnt [4]);
        check_count(cur_name, "acc count", cnt[3], acc_result_cnt_o);
        check_count(cur_name, "pre count", cnt[SRC_PRE], pre_widen_cnt_o);
        check_count(cur_name, "curr count", cnt[SRC_CURR], curr_widen_cnt_o);
        check_count(cur_name, "cache count", cnt[SRC_CACHE], cache_widen_cnt_o);
    endtask

    //////////////////////////////
    // one track with its inline model
    //////////////////////////////

    task automatic run_track(input int r);
        int         vcnt;
        int         k;
        int         r_eff;
        int         w_eff;
        int         gap;
        int         last_hit [N_SRC];
        sample_t    data;
        sample_t    prev_data;
        logic       pre;
        src_vec_t   hit;
        src_vec_t   wid;
        logic       acc;
        logic [3:0] ev;
        logic [3:0] ev_prev;
        evt_cnt_t   cnt [4];

        cur_name = rows[r].name;
        // zero ratio and zero width both act as one
        r_eff = (rows[r].ratio == '0) ? 1 : int'(rows[r].ratio);
        w_eff = (rows[r].width == '0) ? 1 : int'(rows[r].width);
        vcnt = 0;
        k = 0;
        ev_prev = '0;
        prev_data = '0;
        for (int i = 0; i < 4; i++) begin
            cnt[i] = '0;
        end
        for (int s = 0; s < N_SRC; s++) begin
            last_hit[s] = -1;
        end

        // setup while start is low
        ds_ratio_i            <= rows[r].ratio;
        ds_ratio_en_i         <= 1'b1;
        curr_thre_i           <= rows[r].curr_thre;
        cache_thre_i          <= rows[r].cache_thre;
        detect_width_i        <= rows[r].width;
        particle_acc_bypass_i <= rows[r].bypass;
        acc_defect_en_i       <= rows[r].en;
        @(posedge clk_i);
        ds_ratio_en_i <= 1'b0;
        laser_start_i <= 1'b1;
        // start edge clears the counters
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        check_all_counts(cnt);
        @(posedge clk_i);

        for (int n = 0; n < rows[r].n_samples; n++) begin
            gap = rand_below(rows[r].gap_max + 1);
            repeat (gap) begin
                laser_vld_i        <= 1'b0;
                pre_track_result_i <= (rand_below(2) == 1);
                @(posedge clk_i);
            end
            data = sample_t'(rand_below(65536));
            pre  = (rand_below(4) == 0);
            laser_vld_i        <= 1'b1;
            laser_data_i       <= data;
            pre_track_result_i <= pre;
            // every nth valid sample from the start edge
            if ((vcnt % r_eff) == 0) begin
                hit[SRC_PRE]   = pre;
                hit[SRC_CURR]  = (data > rows[r].curr_thre);
                // rise over the last kept sample but never on the first
                hit[SRC_CACHE] = (k != 0) &&
                                 (int'(data) > int'(prev_data) + int'(rows[r].cache_thre));
                for (int s = 0; s < N_SRC; s++) begin
                    if (hit[s]) begin
                        last_hit[s] = k;
                    end
                    wid[s] = (last_hit[s] >= 0) && (k - last_hit[s] < w_eff);
                end
                acc = rows[r].en & (|(wid & ~rows[r].bypass));
                ev = {acc, wid};
                for (int i = 0; i < 4; i++) begin
                    if (ev[i] && !ev_prev[i]) begin
                        cnt[i] = cnt[i] + evt_cnt_t'(1);
                    end
                end
                ev_prev = ev;
                exp_data.push_back(data);
                exp_wid.push_back(wid);
                exp_acc.push_back(acc);
                prev_data = data;
                k++;
            end
            vcnt++;
            @(posedge clk_i);
        end
        laser_vld_i <= 1'b0;

        // drain then let the counters settle
        while (exp_data.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        check_all_counts(cnt);
        @(posedge clk_i);
        laser_start_i <= 1'b0;
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////

    // strobes matched in order without cycle alignment
    always @(negedge clk_i) begin
        if (!reset_i && filter_acc_vld_o === 1'b1) begin
            if (exp_data.size() == 0) begin
                err_cnt++;
                $display("unexpected output strobe in test %s", cur_name);
            end else begin
                check_sample(cur_name, "data", exp_data.pop_front(), filter_acc_data_o);
                check_src_vec(cur_name, "widened", exp_wid.pop_front(),
                              {acc_cache_result_o, acc_curr_result_o, acc_pre_result_o});
                check_bit(cur_name, "acc result", exp_acc.pop_front(), filter_acc_result_o);
            end
        end
    end

    // watchdog
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (limit > 0 && cycle_cnt >= limit) begin
            $display("timeout: run did not end within %0d cycles", limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int total;
        int max_gap;

        seed                  = 5694;
        reset_i               = 1'b1;
        ds_ratio_i            = '0;
        ds_ratio_en_i         = 1'b0;
        laser_start_i         = 1'b0;
        laser_vld_i           = 1'b0;
        laser_data_i          = '0;
        pre_track_result_i    = 1'b0;
        curr_thre_i           = '0;
        cache_thre_i          = '0;
        detect_width_i        = '0;
        particle_acc_bypass_i = '0;
        acc_defect_en_i       = 1'b0;
        load_table();

        // raw samples times longest gap plus setup and drain per track
        total = 0;
        max_gap = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total += rows[r].n_samples;
            if (rows[r].gap_max > max_gap) begin
                max_gap = rows[r].gap_max;
            end
        end
        limit = total * (max_gap + 1) + N_ROWS * 40 + 100;

        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        for (int r = 0; r < N_ROWS; r++) begin
            run_track(r);
        end
        repeat (4) @(posedge clk_i);

        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* design/laser_particle_detect.sv */
`timescale 1ns/100ps

module laser_particle_detect (
    input  logic                     clk_i,
    input  logic                     reset_i,

    // downsample setup
    input  laser_data_pkg::ratio_t   ds_ratio_i,
    input  logic                     ds_ratio_en_i,

    // current track stream
    input  logic                     laser_start_i,
    input  logic                     laser_vld_i,
    input  laser_data_pkg::sample_t  laser_data_i,
    input  logic                     pre_track_result_i,

    // detection setup
    input  laser_data_pkg::thre_t    curr_thre_i,
    input  laser_data_pkg::thre_t    cache_thre_i,
    input  laser_data_pkg::width_t   detect_width_i,
    input  laser_ctrl_pkg::bypass_t  particle_acc_bypass_i,
    input  logic                     acc_defect_en_i,

    // accumulated result stream
    output logic                     filter_acc_vld_o,
    output laser_data_pkg::sample_t  filter_acc_data_o,
    output logic                     filter_acc_result_o,
    output logic                     acc_pre_result_o,
    output logic                     acc_curr_result_o,
    output logic                     acc_cache_result_o,

    // per-track statistics
    output laser_data_pkg::evt_cnt_t acc_result_cnt_o,
    output laser_data_pkg::evt_cnt_t pre_widen_cnt_o,
    output laser_data_pkg::evt_cnt_t curr_widen_cnt_o,
    output laser_data_pkg::evt_cnt_t cache_widen_cnt_o
);

    import laser_ctrl_pkg::*;

    // widened source bits, aligned with filter_acc_vld_o
    src_vec_t widen;

    ds_sample_if     ds_bus ();
    filter_result_if res_bus ();

    //////////////////////////////
    // stage 1, thinning
    //////////////////////////////

    uniform_downsample i_downsample (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .ds_ratio_i         (ds_ratio_i),
        .ds_ratio_en_i      (ds_ratio_en_i),
        .laser_start_i      (laser_start_i),
        .laser_vld_i        (laser_vld_i),
        .laser_data_i       (laser_data_i),
        .pre_track_result_i (pre_track_result_i),
        .ds_o               (ds_bus.source)
    );

    //////////////////////////////
    // stage 2, threshold tests
    //////////////////////////////

    particle_filter i_filter (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .curr_thre_i  (curr_thre_i),
        .cache_thre_i (cache_thre_i),
        .ds_i         (ds_bus.sink),
        .res_o        (res_bus.source)
    );

    //////////////////////////////
    // stage 3, widen and combine
    //////////////////////////////

    acc_flag_generate i_acc_flag (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .detect_width_i        (detect_width_i),
        .particle_acc_bypass_i (particle_acc_bypass_i),
        .acc_defect_en_i       (acc_defect_en_i),
        .res_i                 (res_bus.sink),
        .widen_o               (widen),
        .acc_vld_o             (filter_acc_vld_o),
        .acc_data_o            (filter_acc_data_o),
        .acc_result_o          (filter_acc_result_o)
    );

    // edge counters on the stage 3 stream
    acc_event_stats i_stats (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .laser_start_i (laser_start_i),
        .vld_i         (filter_acc_vld_o),
        .acc_result_i  (filter_acc_result_o),
        .widen_i       (widen),
        .acc_cnt_o     (acc_result_cnt_o),
        .pre_cnt_o     (pre_widen_cnt_o),
        .curr_cnt_o    (curr_widen_cnt_o),
        .cache_cnt_o   (cache_widen_cnt_o)
    );

    assign acc_pre_result_o   = widen[SRC_PRE];
    assign acc_curr_result_o  = widen[SRC_CURR];
    assign acc_cache_result_o = widen[SRC_CACHE];

endmodule

/* design/acc_event_stats.sv */
`timescale 1ns/100ps

module acc_event_stats (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      laser_start_i,
    input  logic                      vld_i,
    input  logic                      acc_result_i,
    input  laser_ctrl_pkg::src_vec_t  widen_i,
    output laser_data_pkg::evt_cnt_t  acc_cnt_o,
    output laser_data_pkg::evt_cnt_t  pre_cnt_o,
    output laser_data_pkg::evt_cnt_t  curr_cnt_o,
    output laser_data_pkg::evt_cnt_t  cache_cnt_o
);

    import laser_data_pkg::*;
    import laser_ctrl_pkg::*;

    // widened sources in the low bits, accumulated result on top
    logic [N_SRC:0] ev_in;
    logic [N_SRC:0] ev_prev_q;
    logic [N_SRC:0] ev_rise;
    evt_cnt_t       cnt_q [N_SRC+1];
    logic           start_d_q;
    logic           start_rise;

    assign ev_in      = {acc_result_i, widen_i};
    // compared against the last valid sample, not the last cycle
    assign ev_rise    = ev_in & ~ev_prev_q;
    assign start_rise = laser_start_i & ~start_d_q;

    //////////////////////////////
    // edge counters
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            start_d_q <= 1'b0;
            ev_prev_q <= '0;
            for (int i = 0; i <= N_SRC; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            start_d_q <= laser_start_i;
            // new track, a high first sample counts as an edge
            if (start_rise) begin
                ev_prev_q <= '0;
                for (int i = 0; i <= N_SRC; i++) begin
                    cnt_q[i] <= '0;
                end
            end else if (vld_i) begin
                ev_prev_q <= ev_in;
                // counting only inside the track
                if (laser_start_i) begin
                    for (int i = 0; i <= N_SRC; i++) begin
                        if (ev_rise[i]) begin
                            cnt_q[i] <= cnt_q[i] + evt_cnt_t'(1);
                        end
                    end
                end
            end
        end
    end

    assign acc_cnt_o   = cnt_q[N_SRC];
    assign pre_cnt_o   = cnt_q[SRC_PRE];
    assign curr_cnt_o  = cnt_q[SRC_CURR];
    assign cache_cnt_o = cnt_q[SRC_CACHE];

endmodule

/* acc_flag/acc_flag_generate.sv */
`timescale 1ns/100ps

module acc_flag_generate (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  laser_data_pkg::width_t   detect_width_i,
    input  laser_ctrl_pkg::bypass_t  particle_acc_bypass_i,
    input  logic                     acc_defect_en_i,
    filter_result_if.sink            res_i,
    output laser_ctrl_pkg::src_vec_t widen_o,
    output logic                     acc_vld_o,
    output laser_data_pkg::sample_t  acc_data_o,
    output logic                     acc_result_o
);

    import laser_data_pkg::*;
    import laser_ctrl_pkg::*;

    // effective window, zero taken as one
    width_t   width_eff;
    // kept samples left in each source window
    width_t   rem_q    [N_SRC];
    width_t   rem_next [N_SRC];
    src_vec_t hit_vec;
    src_vec_t widen_next;
    logic     acc_next;

    assign width_eff = (detect_width_i == '0) ? width_t'(1) : detect_width_i;

    // source order as in laser_ctrl_pkg
    assign hit_vec[SRC_PRE]   = res_i.pre_hit;
    assign hit_vec[SRC_CURR]  = res_i.curr_hit;
    assign hit_vec[SRC_CACHE] = res_i.cache_hit;

    //////////////////////////////
    // window counters
    //////////////////////////////

    // hit reloads the window
    // first sample drops what is left of the last track
    // otherwise one step down per kept sample
    always_comb begin
        for (int s = 0; s < N_SRC; s++) begin
            if (hit_vec[s]) begin
                rem_next[s] = width_eff;
            end else if (res_i.first) begin
                rem_next[s] = '0;
            end else if (rem_q[s] != '0) begin
                rem_next[s] = rem_q[s] - width_t'(1);
            end else begin
                rem_next[s] = '0;
            end
            widen_next[s] = (rem_next[s] != '0);
        end
    end

    // unbypassed sources only, then the global enable
    assign acc_next = acc_defect_en_i & (|(widen_next & ~particle_acc_bypass_i));

    //////////////////////////////
    // registered results
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int s = 0; s < N_SRC; s++) begin
                rem_q[s] <= '0;
            end
            widen_o      <= '0;
            acc_vld_o    <= 1'b0;
            acc_result_o <= 1'b0;
        end else begin
            acc_vld_o <= res_i.vld;
            // state only moves on kept samples
            if (res_i.vld) begin
                for (int s = 0; s < N_SRC; s++) begin
                    rem_q[s] <= rem_next[s];
                end
                widen_o      <= widen_next;
                acc_result_o <= acc_next;
            end
        end
    end

    // sample payload
    always_ff @(posedge clk_i) begin
        if (res_i.vld) begin
            acc_data_o <= res_i.data;
        end
    end

endmodule

/* particle_filter/particle_filter.sv */
`timescale 1ns/100ps

module particle_filter (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  laser_data_pkg::thre_t curr_thre_i,
    input  laser_data_pkg::thre_t cache_thre_i,
    ds_sample_if.sink             ds_i,
    filter_result_if.source       res_o
);

    import laser_data_pkg::*;

    // last kept sample, base of the rise test
    sample_t           prev_q;
    // prev plus threshold, one extra bit so it cannot wrap
    logic [SAMPLE_W:0] rise_lim;
    logic              curr_hit;
    logic              cache_hit;

    //////////////////////////////
    // threshold tests
    //////////////////////////////

    // absolute level test
    assign curr_hit  = ds_i.data > curr_thre_i;

    assign rise_lim  = {1'b0, prev_q} + {1'b0, cache_thre_i};
    // prev_q belongs to the last track on a first sample
    assign cache_hit = ~ds_i.first & ({1'b0, ds_i.data} > rise_lim);

    //////////////////////////////
    // registered verdicts
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_o.vld       <= 1'b0;
            res_o.pre_hit   <= 1'b0;
            res_o.curr_hit  <= 1'b0;
            res_o.cache_hit <= 1'b0;
            res_o.first     <= 1'b0;
        end else begin
            res_o.vld <= ds_i.vld;
            // verdicts held between strobes
            if (ds_i.vld) begin
                res_o.pre_hit   <= ds_i.pre_hit;
                res_o.curr_hit  <= curr_hit;
                res_o.cache_hit <= cache_hit;
                res_o.first     <= ds_i.first;
            end
        end
    end

    // sample payload and rise base
    always_ff @(posedge clk_i) begin
        if (ds_i.vld) begin
            res_o.data <= ds_i.data;
            prev_q     <= ds_i.data;
        end
    end

endmodule

/* downsample/uniform_downsample.sv */
`timescale 1ns/100ps

module uniform_downsample (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  laser_data_pkg::ratio_t  ds_ratio_i,
    input  logic                    ds_ratio_en_i,
    input  logic                    laser_start_i,
    input  logic                    laser_vld_i,
    input  laser_data_pkg::sample_t laser_data_i,
    input  logic                    pre_track_result_i,
    ds_sample_if.source             ds_o
);

    import laser_data_pkg::*;
    import laser_ctrl_pkg::*;

    ratio_t ratio_q;
    ratio_t keep_cnt_q;
    ratio_t cnt_base;
    logic   start_d_q;
    logic   start_rise;
    logic   first_pend_q;
    logic   keep;

    //////////////////////////////
    // ratio register
    //////////////////////////////

    // zero is taken as one
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ratio_q <= ratio_t'(DEFAULT_RATIO);
        end else if (ds_ratio_en_i) begin
            ratio_q <= (ds_ratio_i == '0) ? ratio_t'(1) : ds_ratio_i;
        end
    end

    //////////////////////////////
    // keep counter
    //////////////////////////////

    assign start_rise = laser_start_i & ~start_d_q;
    // a start edge restarts the count in the same cycle
    assign cnt_base   = start_rise ? '0 : keep_cnt_q;
    // keep on count zero, first valid after the edge included
    assign keep       = laser_vld_i & (cnt_base == '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            start_d_q    <= 1'b0;
            keep_cnt_q   <= '0;
            first_pend_q <= 1'b0;
        end else begin
            start_d_q <= laser_start_i;
            // counts valid samples only, wraps at ratio-1
            // >= also covers a ratio shrunk mid count
            if (laser_vld_i) begin
                if (cnt_base >= ratio_q - ratio_t'(1)) begin
                    keep_cnt_q <= '0;
                end else begin
                    keep_cnt_q <= cnt_base + ratio_t'(1);
                end
            end else if (start_rise) begin
                keep_cnt_q <= '0;
            end
            // first tag waits for the first kept sample
            if (keep) begin
                first_pend_q <= 1'b0;
            end else if (start_rise) begin
                first_pend_q <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // output stage
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ds_o.vld     <= 1'b0;
            ds_o.pre_hit <= 1'b0;
            ds_o.first   <= 1'b0;
        end else begin
            ds_o.vld <= keep;
            if (keep) begin
                ds_o.pre_hit <= pre_track_result_i;
                ds_o.first   <= start_rise | first_pend_q;
            end
        end
    end

    // sample payload
    always_ff @(posedge clk_i) begin
        if (keep) begin
            ds_o.data <= laser_data_i;
        end
    end

endmodule

/* common/filter_result_if.sv */
`timescale 1ns/100ps

interface filter_result_if;

    import laser_data_pkg::*;

    // valid-only strobe, no back-pressure
    logic    vld;
    sample_t data;
    // verdicts of the three sources
    logic    pre_hit;
    logic    curr_hit;
    logic    cache_hit;
    // track start tag passed along
    logic    first;

    modport source (
        output vld, output data, output pre_hit,
        output curr_hit, output cache_hit, output first
    );
    modport sink (
        input  vld, input  data, input  pre_hit,
        input  curr_hit, input  cache_hit, input  first
    );

endinterface

/* common/ds_sample_if.sv */
`timescale 1ns/100ps

interface ds_sample_if;

    import laser_data_pkg::*;

    // one-cycle strobe per kept sample
    logic    vld;
    // kept sample
    sample_t data;
    // previous track verdict seen with this raw sample
    logic    pre_hit;
    // first kept sample since the track start edge
    logic    first;

    modport source (output vld, output data, output pre_hit, output first);
    modport sink   (input  vld, input  data, input  pre_hit, input  first);

endinterface

/* common/laser_ctrl_pkg.sv */
package laser_ctrl_pkg;

    //////////////////////////////
    // result sources
    //////////////////////////////

    // pre track, current threshold, cache rise
    localparam int N_SRC     = 3;

    // bit positions in the source vectors
    localparam int SRC_PRE   = 0;
    localparam int SRC_CURR  = 1;
    localparam int SRC_CACHE = 2;

    // one bit per source, widened results and counter inputs
    typedef logic [N_SRC-1:0] src_vec_t;

    // set bit drops that source from the accumulated result
    typedef logic [N_SRC-1:0] bypass_t;

    //////////////////////////////
    // configuration defaults
    //////////////////////////////

    // no thinning until software loads a ratio
    localparam int unsigned DEFAULT_RATIO = 1;

endpackage

/* common/laser_data_pkg.sv */
package laser_data_pkg;

    //////////////////////////////
    // data path widths
    //////////////////////////////

    // adc sample width
    localparam int SAMPLE_W  = 16;
    // threshold width, same scale as a sample
    localparam int THRE_W    = 16;
    // widening length, in kept samples
    localparam int WIDTH_W   = 16;
    // downsample ratio
    localparam int RATIO_W   = 16;
    // per-track event counters
    localparam int EVT_CNT_W = 32;

    //////////////////////////////
    // data path types
    //////////////////////////////

    // one laser sample, unsigned
    typedef logic [SAMPLE_W-1:0]  sample_t;
    // absolute or rise threshold
    typedef logic [THRE_W-1:0]    thre_t;
    // number of kept samples a hit is stretched over
    typedef logic [WIDTH_W-1:0]   width_t;
    // keep one sample out of this many
    typedef logic [RATIO_W-1:0]   ratio_t;
    // rising edge count within one track
    typedef logic [EVT_CNT_W-1:0] evt_cnt_t;

endpackage
